// File: project.f
pcie_read_pkg.sv
desc_fifo.sv
scratchpad_ram.sv
read_request_intake.sv
read_slot_table.sv
core_stream_source.sv
pcie_cont_read.sv
tb_pcie_cont_read.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_pcie_cont_read -o sim_tb
./obj_dir/sim_tb

// File: tb_pcie_cont_read.sv
`timescale 1ns/1ps

module tb_pcie_cont_read;
  import pcie_read_pkg::*;

  localparam int wait_limit = 2000;
  localparam int entry_count = 8;

  typedef struct packed {
    logic                   from_core;
    logic [pcie_addr_w-1:0] pcie_addr;
    logic [len_w-1:0]       len;
    logic [core_w-1:0]      core_id;
    logic [core_addr_w-1:0] core_addr;
    logic [4:0]             dest_lo;
    logic [host_tag_w-1:0]  host_tag;
  } req_entry_t;

  logic pcie_clk;
  logic pcie_rst;
  logic dma_enable;
  host_req_t host_req;
  logic host_req_valid;
  logic host_req_ready;
  logic [host_tag_w-1:0] host_status_tag;
  logic host_status_valid;
  core_ctrl_t core_req;
  logic [core_w-1:0] core_id;
  logic core_req_valid;
  logic core_req_ready;
  logic [data_w-1:0] cores_rx_tdata;
  logic [keep_w-1:0] cores_rx_tkeep;
  logic [dest_w-1:0] cores_rx_tdest;
  logic cores_rx_tlast;
  logic cores_rx_tvalid;
  logic cores_rx_tready;
  dma_desc_t dma_desc;
  logic dma_desc_valid;
  logic dma_desc_ready;
  logic [slot_w-1:0] dma_status_slot;
  logic dma_status_valid;
  ram_wr_t ram_wr;
  logic ram_wr_valid;

  req_entry_t            table_q [entry_count];
  dma_desc_t             exp_desc_q [$];
  logic [host_tag_w-1:0] status_q [$];
  logic [data_w-1:0]     slot_words [slot_count][16];
  logic [slot_count-1:0] busy;
  int                    slot_entry [slot_count];

  pcie_cont_read u_pcie_cont_read (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #2 pcie_clk = ~pcie_clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic mismatch(input string what);
    stop_run($sformatf("Fail at %0t ns: %s", $time, what));
  endtask

  task automatic compare_desc(input dma_desc_t got, input dma_desc_t exp);
    if (got !== exp) begin
      mismatch($sformatf("descriptor got %h expected %h", got, exp));
    end
  endtask

  task automatic compare_beat(input logic [data_w-1:0] data, input logic [keep_w-1:0] keep,
                              input logic [dest_w-1:0] dest, input logic last,
                              input logic [data_w-1:0] exp_data,
                              input logic [keep_w-1:0] exp_keep,
                              input logic [dest_w-1:0] exp_dest, input logic exp_last);
    if (data !== exp_data || keep !== exp_keep || dest !== exp_dest || last !== exp_last) begin
      mismatch($sformatf("beat data %h keep %h dest %h last %b, expected %h %h %h %b",
                         data, keep, dest, last, exp_data, exp_keep, exp_dest, exp_last));
    end
  endtask

  task automatic compare_status(input logic [host_tag_w-1:0] got,
                                input logic [host_tag_w-1:0] exp);
    if (got !== exp) begin
      mismatch($sformatf("host status tag %h expected %h", got, exp));
    end
  endtask

  task automatic next_drive();
    @(posedge pcie_clk);
    #1;
  endtask

  function automatic req_entry_t make_entry(input logic src, input logic [63:0] addr,
                                            input int len, input int cid, input int caddr,
                                            input int dlo, input logic [31:0] tag);
    req_entry_t e;
    e.from_core = src;
    e.pcie_addr = addr;
    e.len       = len_w'(len);
    e.core_id   = core_w'(cid);
    e.core_addr = core_addr_w'(caddr);
    e.dest_lo   = 5'(dlo);
    e.host_tag  = tag;
    return e;
  endfunction

  // Host requests put the core id on top of a zero low field
  function automatic logic [dest_w-1:0] expected_dest(input req_entry_t e);
    return e.from_core ? {e.core_id, e.dest_lo} : {e.core_id, 5'b0};
  endfunction

  function automatic int lowest_free();
    for (int i = 0; i < slot_count; i++) begin
      if (!busy[i]) return i;
    end
    return -1;
  endfunction

  task automatic drive_req(input int idx);
    req_entry_t e;
    e = table_q[idx];
    if (e.from_core) begin
      core_req = '0;
      core_req.pcie_addr = e.pcie_addr;
      core_req.core_addr = e.core_addr;
      core_req.dest_lo   = e.dest_lo;
      core_req.len       = e.len;
      core_id            = e.core_id;
      core_req_valid     = 1'b1;
    end else begin
      host_req.pcie_addr = e.pcie_addr;
      host_req.ram_addr  = {12'b0, e.core_id, e.core_addr};
      host_req.len       = e.len;
      host_req.tag       = e.host_tag;
      host_req_valid     = 1'b1;
    end
  endtask

  // Waits for the handshake and records the slot the request must get
  task automatic wait_accept(input int idx, output int slot);
    req_entry_t e;
    dma_desc_t  d;
    logic       rdy;
    int         n;
    e = table_q[idx];
    for (n = 0; n < wait_limit; n++) begin
      #2;
      rdy = e.from_core ? core_req_ready : host_req_ready;
      if (rdy) break;
      next_drive();
    end
    if (n == wait_limit) stop_run("Timeout waiting for a request to be accepted");
    // A waiting core request must be held off while the host goes in
    if (!e.from_core && core_req_valid && core_req_ready !== 1'b0) begin
      stop_run("Core request ready while a host request is valid");
    end
    slot = lowest_free();
    busy[slot] = 1'b1;
    slot_entry[slot] = idx;
    d.pcie_addr = e.pcie_addr;
    d.ram_addr  = 16'(slot * slot_bytes);
    d.len       = e.len;
    d.tag       = slot_w'(slot);
    exp_desc_q.push_back(d);
    next_drive();
    if (e.from_core) core_req_valid = 1'b0;
    else host_req_valid = 1'b0;
  endtask

  // DMA engine model writes the slot region, then reports completion
  task automatic complete_slot(input int slot);
    int n;
    for (n = 0; n < wait_limit && exp_desc_q.size() != 0; n++) next_drive();
    if (n == wait_limit) stop_run("Timeout waiting for the DMA descriptor");
    for (int w = 0; w < 16; w++) begin
      slot_words[slot][w] = {$urandom, $urandom, $urandom, $urandom};
      ram_wr.addr  = {slot_w'(slot), 4'(w)};
      ram_wr.data  = slot_words[slot][w];
      ram_wr.be    = '1;
      ram_wr_valid = 1'b1;
      next_drive();
    end
    ram_wr_valid     = 1'b0;
    dma_status_slot  = slot_w'(slot);
    dma_status_valid = 1'b1;
    next_drive();
    dma_status_valid = 1'b0;
  endtask

  task automatic receive_stream(input int slot);
    req_entry_t        e;
    int                beats;
    int                beat;
    int                n;
    int                rem;
    logic [data_w-1:0] exp_data;
    logic [keep_w-1:0] exp_keep;
    e = table_q[slot_entry[slot]];
    beats = 1 + (int'(e.len) + 15) / 16;
    rem = int'(e.len) % 16;
    beat = 0;
    for (n = 0; n < wait_limit; n++) begin
      cores_rx_tready = ($urandom % 4) != 0;
      #2;
      if (cores_rx_tvalid && cores_rx_tready) begin
        exp_keep = '1;
        if (beat == 0) begin
          exp_data = '0;
          exp_data[47:32] = e.core_addr;
        end else begin
          exp_data = slot_words[slot][beat-1];
          if (beat == beats - 1 && rem != 0) exp_keep = keep_w'((1 << rem) - 1);
        end
        compare_beat(cores_rx_tdata, cores_rx_tkeep, cores_rx_tdest, cores_rx_tlast,
                     exp_data, exp_keep, expected_dest(e), beat == beats - 1);
        beat++;
      end
      next_drive();
      if (beat == beats) break;
    end
    if (n == wait_limit) stop_run("Timeout waiting for the stream to the core");
    cores_rx_tready = 1'b0;
  endtask

  // Exactly one status for a non-zero host tag, none otherwise
  task automatic check_status(input int slot);
    req_entry_t e;
    int         n;
    e = table_q[slot_entry[slot]];
    if (!e.from_core && e.host_tag != '0) begin
      for (n = 0; n < wait_limit && status_q.size() == 0; n++) next_drive();
      if (n == wait_limit) stop_run("Timeout waiting for host status");
      compare_status(status_q.pop_front(), e.host_tag);
    end
    repeat (4) next_drive();
    if (status_q.size() != 0) stop_run("Unexpected extra host status pulse");
    busy[slot] = 1'b0;
  endtask

  task automatic run_one(input int idx);
    int slot;
    drive_req(idx);
    wait_accept(idx, slot);
    complete_slot(slot);
    receive_stream(slot);
    check_status(slot);
  endtask

  initial begin
    dma_desc_t exp;
    forever begin
      @(posedge pcie_clk);
      #3;
      if (!pcie_rst && dma_desc_valid && dma_desc_ready) begin
        if (exp_desc_q.size() == 0) stop_run("DMA descriptor issued without a request");
        exp = exp_desc_q.pop_front();
        compare_desc(dma_desc, exp);
      end
      if (!pcie_rst && host_status_valid) status_q.push_back(host_status_tag);
    end
  end

  initial begin
    int slot_a;
    int slot_b;
    int n;
    void'($urandom(90));
    table_q[0] = make_entry(1'b0, 64'h0000_0010_0000_1000, 1, 3, 16'h1234, 0, 32'hA5A5_0001);
    table_q[1] = make_entry(1'b1, 64'h0000_0020_0000_2000, 16, 5, 16'h4000, 7, '0);
    table_q[2] = make_entry(1'b0, 64'h0000_0030_0000_3000, 17, 9, 16'h0abc, 0, '0);
    table_q[3] = make_entry(1'b1, 64'h0000_0040_0000_4000, 256, 15, 16'hfff0, 31, '0);
    table_q[4] = make_entry(1'b0, 64'h0000_0050_0000_5000, 100, 0, 16'h0100, 0, 32'h0000_0042);
    table_q[5] = make_entry(1'b1, 64'h0000_0060_0000_6000, 33, 6, 16'h2200, 18, '0);
    table_q[6] = make_entry(1'b0, 64'h0000_0070_0000_7000, 255, 12, 16'h8000, 0, 32'hdead_beef);
    table_q[7] = make_entry(1'b1, 64'h0000_0080_0000_8000, 48, 2, 16'h0044, 1, '0);
    pcie_rst = 1'b1;
    dma_enable = 1'b0;
    host_req = '0;
    host_req_valid = 1'b0;
    core_req = '0;
    core_id = '0;
    core_req_valid = 1'b0;
    cores_rx_tready = 1'b0;
    dma_desc_ready = 1'b1;
    dma_status_slot = '0;
    dma_status_valid = 1'b0;
    ram_wr = '0;
    ram_wr_valid = 1'b0;
    busy = '0;
    repeat (2) next_drive();
    pcie_rst = 1'b0;
    dma_enable = 1'b1;

    for (int i = 0; i < entry_count; i++) run_one(i);

    // Host and core valid together
    drive_req(6);
    drive_req(5);
    wait_accept(6, slot_a);
    wait_accept(5, slot_b);
    complete_slot(slot_a);
    receive_stream(slot_a);
    check_status(slot_a);
    complete_slot(slot_b);
    receive_stream(slot_b);
    check_status(slot_b);

    // Fill every slot, then the slot freed by one stream goes to the next request
    for (int i = 0; i < slot_count; i++) begin
      drive_req(i);
      wait_accept(i, slot_a);
    end
    for (n = 0; n < 6; n++) begin
      #2;
      if (host_req_ready !== 1'b0 || core_req_ready !== 1'b0) begin
        stop_run("Request ready with all slots outstanding");
      end
      next_drive();
    end
    complete_slot(3);
    receive_stream(3);
    check_status(3);
    drive_req(4);
    wait_accept(4, slot_a);
    for (int s = 0; s < slot_count; s++) begin
      complete_slot(s);
      receive_stream(s);
      check_status(s);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: pcie_cont_read.sv
`timescale 1ns/1ps

module pcie_cont_read (
  input  logic                                  pcie_clk,
  input  logic                                  pcie_rst,
  input  logic                                  dma_enable,
  input  pcie_read_pkg::host_req_t              host_req,
  input  logic                                  host_req_valid,
  output logic                                  host_req_ready,
  output logic [pcie_read_pkg::host_tag_w-1:0]  host_status_tag,
  output logic                                  host_status_valid,
  input  pcie_read_pkg::core_ctrl_t             core_req,
  input  logic [pcie_read_pkg::core_w-1:0]      core_id,
  input  logic                                  core_req_valid,
  output logic                                  core_req_ready,
  output logic [pcie_read_pkg::data_w-1:0]      cores_rx_tdata,
  output logic [pcie_read_pkg::keep_w-1:0]      cores_rx_tkeep,
  output logic [pcie_read_pkg::dest_w-1:0]      cores_rx_tdest,
  output logic                                  cores_rx_tlast,
  output logic                                  cores_rx_tvalid,
  input  logic                                  cores_rx_tready,
  output pcie_read_pkg::dma_desc_t              dma_desc,
  output logic                                  dma_desc_valid,
  input  logic                                  dma_desc_ready,
  input  logic [pcie_read_pkg::slot_w-1:0]      dma_status_slot,
  input  logic                                  dma_status_valid,
  input  pcie_read_pkg::ram_wr_t                ram_wr,
  input  logic                                  ram_wr_valid
);
  import pcie_read_pkg::*;

  logic [slot_w-1:0]     slot_free_idx;
  logic                  slot_avail;
  logic                  alloc_valid;
  logic [slot_w-1:0]     alloc_slot;
  slot_rec_t             alloc_rec;
  dma_desc_t             desc_reg;
  logic                  desc_reg_valid;
  logic                  desc_reg_ready;
  stream_desc_t          sdesc_reg;
  logic                  sdesc_reg_valid;
  logic                  sdesc_reg_ready;
  stream_desc_t          sdesc;
  logic                  sdesc_valid;
  logic                  sdesc_ready;
  logic [ram_addr_w-1:0] rd_addr;
  logic [data_w-1:0]     rd_data;
  logic                  stream_done;
  logic [slot_w-1:0]     done_slot;

  read_request_intake u_read_request_intake (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .core_req       (core_req),
    .core_id        (core_id),
    .core_req_valid (core_req_valid),
    .core_req_ready (core_req_ready),
    .slot_free_idx  (slot_free_idx),
    .slot_avail     (slot_avail),
    .alloc_valid    (alloc_valid),
    .alloc_slot     (alloc_slot),
    .alloc_rec      (alloc_rec),
    .desc_out       (desc_reg),
    .desc_valid     (desc_reg_valid),
    .desc_ready     (desc_reg_ready)
  );

  read_slot_table u_read_slot_table (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .alloc_valid       (alloc_valid),
    .alloc_slot        (alloc_slot),
    .alloc_rec         (alloc_rec),
    .slot_free_idx     (slot_free_idx),
    .slot_avail        (slot_avail),
    .dma_status_slot   (dma_status_slot),
    .dma_status_valid  (dma_status_valid),
    .sdesc             (sdesc_reg),
    .sdesc_valid       (sdesc_reg_valid),
    .sdesc_ready       (sdesc_reg_ready),
    .stream_done       (stream_done),
    .done_slot         (done_slot),
    .host_status_tag   (host_status_tag),
    .host_status_valid (host_status_valid)
  );

  desc_fifo #(
    .payload_t  (dma_desc_t),
    .depth_log2 (slot_w)
  ) u_dma_desc_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din        (desc_reg),
    .din_valid  (desc_reg_valid),
    .din_ready  (desc_reg_ready),
    .dout       (dma_desc),
    .dout_valid (dma_desc_valid),
    .dout_ready (dma_desc_ready)
  );

  // Depth matches slot_count so it never fills
  desc_fifo #(
    .payload_t  (stream_desc_t),
    .depth_log2 (slot_w)
  ) u_stream_desc_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din        (sdesc_reg),
    .din_valid  (sdesc_reg_valid),
    .din_ready  (sdesc_reg_ready),
    .dout       (sdesc),
    .dout_valid (sdesc_valid),
    .dout_ready (sdesc_ready)
  );

  scratchpad_ram u_scratchpad_ram (
    .pcie_clk (pcie_clk),
    .wr       (ram_wr),
    .wr_valid (ram_wr_valid),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  core_stream_source u_core_stream_source (
    .pcie_clk    (pcie_clk),
    .pcie_rst    (pcie_rst),
    .dma_enable  (dma_enable),
    .sdesc       (sdesc),
    .sdesc_valid (sdesc_valid),
    .sdesc_ready (sdesc_ready),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .tdata       (cores_rx_tdata),
    .tkeep       (cores_rx_tkeep),
    .tdest       (cores_rx_tdest),
    .tlast       (cores_rx_tlast),
    .tvalid      (cores_rx_tvalid),
    .tready      (cores_rx_tready),
    .stream_done (stream_done),
    .done_slot   (done_slot)
  );

endmodule

// File: core_stream_source.sv
`timescale 1ns/1ps

module core_stream_source (
  input  logic                                  pcie_clk,
  input  logic                                  pcie_rst,
  input  logic                                  dma_enable,
  input  pcie_read_pkg::stream_desc_t           sdesc,
  input  logic                                  sdesc_valid,
  output logic                                  sdesc_ready,
  output logic [pcie_read_pkg::ram_addr_w-1:0]  rd_addr,
  input  logic [pcie_read_pkg::data_w-1:0]      rd_data,
  output logic [pcie_read_pkg::data_w-1:0]      tdata,
  output logic [pcie_read_pkg::keep_w-1:0]      tkeep,
  output logic [pcie_read_pkg::dest_w-1:0]      tdest,
  output logic                                  tlast,
  output logic                                  tvalid,
  input  logic                                  tready,
  output logic                                  stream_done,
  output logic [pcie_read_pkg::slot_w-1:0]      done_slot
);
  import pcie_read_pkg::*;

  stream_state_e                   state;
  stream_desc_t                    cur;
  logic [ram_addr_w-slot_w-1:0]    word_idx;
  logic [ram_addr_w-slot_w-1:0]    last_word;
  logic [len_w-1:0]                len_m1;
  logic [$clog2(keep_w)-1:0]       len_rem;
  logic [keep_w-1:0]               keep_last;
  logic [data_w-1:0]               header;

  assign sdesc_ready = (state == s_idle) && dma_enable;
  assign len_m1      = sdesc.rec.len - 1'b1;
  assign len_rem     = cur.rec.len[$clog2(keep_w)-1:0];
  assign keep_last   = (len_rem == '0) ? '1 : (keep_w'(1) << len_rem) - 1'b1;

  always_comb begin
    header = '0;
    header[32 +: core_addr_w] = cur.rec.core_addr;
  end

  assign tvalid = state != s_idle;
  assign tdest  = cur.rec.dest;
  assign tlast  = (state == s_data) && (word_idx == last_word);
  assign tdata  = (state == s_header) ? header : rd_data;
  assign tkeep  = tlast ? keep_last : '1;

  // Address runs one word ahead so rd_data is ready when a beat moves
  always_comb begin
    if (state == s_idle) begin
      rd_addr = {sdesc.slot, {(ram_addr_w-slot_w){1'b0}}};
    end else if (state == s_data && tready) begin
      rd_addr = {cur.slot, word_idx + 1'b1};
    end else begin
      rd_addr = {cur.slot, word_idx};
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (sdesc_valid && sdesc_ready) begin
      cur       <= sdesc;
      last_word <= len_m1[$clog2(keep_w) +: ram_addr_w-slot_w];
    end
    done_slot <= cur.slot;
    if (pcie_rst) begin
      state       <= s_idle;
      word_idx    <= '0;
      stream_done <= 1'b0;
    end else begin
      stream_done <= tlast && tready;
      case (state)
        s_idle: begin
          word_idx <= '0;
          if (sdesc_valid && sdesc_ready) begin
            state <= s_header;
          end
        end
        s_header: begin
          if (tready) begin
            state <= s_data;
          end
        end
        s_data: begin
          if (tready) begin
            if (tlast) begin
              state <= s_idle;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

// File: read_slot_table.sv
`timescale 1ns/1ps

module read_slot_table (
  input  logic                                  pcie_clk,
  input  logic                                  pcie_rst,
  input  logic                                  alloc_valid,
  input  logic [pcie_read_pkg::slot_w-1:0]      alloc_slot,
  input  pcie_read_pkg::slot_rec_t              alloc_rec,
  output logic [pcie_read_pkg::slot_w-1:0]      slot_free_idx,
  output logic                                  slot_avail,
  input  logic [pcie_read_pkg::slot_w-1:0]      dma_status_slot,
  input  logic                                  dma_status_valid,
  output pcie_read_pkg::stream_desc_t           sdesc,
  output logic                                  sdesc_valid,
  input  logic                                  sdesc_ready,
  input  logic                                  stream_done,
  input  logic [pcie_read_pkg::slot_w-1:0]      done_slot,
  output logic [pcie_read_pkg::host_tag_w-1:0]  host_status_tag,
  output logic                                  host_status_valid
);
  import pcie_read_pkg::*;

  logic [slot_count-1:0] free_mask;
  logic [slot_count-1:0] free_next;
  slot_rec_t             rec_mem [slot_count];
  slot_rec_t             done_rec;

  // Lowest-numbered free slot wins
  always_comb begin
    slot_free_idx = '0;
    for (int i = slot_count - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        slot_free_idx = slot_w'(i);
      end
    end
  end

  assign slot_avail = |free_mask;
  assign done_rec   = rec_mem[done_slot];

  // Allocation and release in one cycle both apply
  always_comb begin
    free_next = free_mask;
    if (alloc_valid) begin
      free_next[alloc_slot] = 1'b0;
    end
    if (stream_done) begin
      free_next[done_slot] = 1'b1;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (alloc_valid) begin
      rec_mem[alloc_slot] <= alloc_rec;
    end
    if (dma_status_valid) begin
      sdesc.slot <= dma_status_slot;
      sdesc.rec  <= rec_mem[dma_status_slot];
    end
    host_status_tag <= done_rec.host_tag;
    if (pcie_rst) begin
      free_mask         <= '1;
      sdesc_valid       <= 1'b0;
      host_status_valid <= 1'b0;
    end else begin
      free_mask         <= free_next;
      sdesc_valid       <= dma_status_valid || (sdesc_valid && !sdesc_ready);
      host_status_valid <= stream_done && (done_rec.host_tag != '0);
    end
  end

endmodule

// File: read_request_intake.sv
`timescale 1ns/1ps

module read_request_intake (
  input  logic                              pcie_clk,
  input  logic                              pcie_rst,
  input  pcie_read_pkg::host_req_t          host_req,
  input  logic                              host_req_valid,
  output logic                              host_req_ready,
  input  pcie_read_pkg::core_ctrl_t         core_req,
  input  logic [pcie_read_pkg::core_w-1:0]  core_id,
  input  logic                              core_req_valid,
  output logic                              core_req_ready,
  input  logic [pcie_read_pkg::slot_w-1:0]  slot_free_idx,
  input  logic                              slot_avail,
  output logic                              alloc_valid,
  output logic [pcie_read_pkg::slot_w-1:0]  alloc_slot,
  output pcie_read_pkg::slot_rec_t          alloc_rec,
  output pcie_read_pkg::dma_desc_t          desc_out,
  output logic                              desc_valid,
  input  logic                              desc_ready
);
  import pcie_read_pkg::*;

  logic host_take;
  logic core_take;

  // Host has fixed priority over the cores
  assign host_req_ready = desc_ready && slot_avail;
  assign core_req_ready = desc_ready && slot_avail && !host_req_valid;

  assign host_take   = host_req_valid && host_req_ready;
  assign core_take   = core_req_valid && core_req_ready;
  assign alloc_valid = host_take || core_take;
  assign alloc_slot  = slot_free_idx;

  always_comb begin
    if (host_take) begin
      alloc_rec.len       = host_req.len;
      alloc_rec.core_addr = host_req.ram_addr[core_addr_w-1:0];
      alloc_rec.dest      = {host_req.ram_addr[core_addr_w +: core_w],
                             {(dest_w-core_w){1'b0}}};
      alloc_rec.host_tag  = host_req.tag;
    end else begin
      alloc_rec.len       = core_req.len;
      alloc_rec.core_addr = core_req.core_addr;
      alloc_rec.dest      = {core_id, core_req.dest_lo};
      alloc_rec.host_tag  = '0;
    end
  end

  // Descriptor register, held until the FIFO takes it
  always_ff @(posedge pcie_clk) begin
    if (alloc_valid) begin
      desc_out.pcie_addr <= host_take ? host_req.pcie_addr : core_req.pcie_addr;
      desc_out.ram_addr  <= 16'(int'(slot_free_idx) * slot_bytes);
      desc_out.len       <= alloc_rec.len;
      desc_out.tag       <= slot_free_idx;
    end
    if (pcie_rst) begin
      desc_valid <= 1'b0;
    end else begin
      desc_valid <= alloc_valid || (desc_valid && !desc_ready);
    end
  end

endmodule

// File: scratchpad_ram.sv
`timescale 1ns/1ps

module scratchpad_ram (
  input  logic                                  pcie_clk,
  input  pcie_read_pkg::ram_wr_t                wr,
  input  logic                                  wr_valid,
  input  logic [pcie_read_pkg::ram_addr_w-1:0]  rd_addr,
  output logic [pcie_read_pkg::data_w-1:0]      rd_data
);
  import pcie_read_pkg::*;

  // 16 words per slot
  logic [data_w-1:0] mem [2**ram_addr_w];

  always_ff @(posedge pcie_clk) begin
    if (wr_valid) begin
      for (int i = 0; i < keep_w; i++) begin
        if (wr.be[i]) begin
          mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
        end
      end
    end
  end

  // One cycle read latency
  always_ff @(posedge pcie_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
  parameter type payload_t  = logic,
  parameter int  depth_log2 = 3
) (
  input  logic     pcie_clk,
  input  logic     pcie_rst,
  input  payload_t din,
  input  logic     din_valid,
  output logic     din_ready,
  output payload_t dout,
  output logic     dout_valid,
  input  logic     dout_ready
);

  payload_t              mem [2**depth_log2];
  logic [depth_log2-1:0] wr_ptr;
  logic [depth_log2-1:0] rd_ptr;
  logic [depth_log2:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  // Top count bit set only when every entry is taken
  assign din_ready  = !count[depth_log2];
  assign dout_valid = count != '0;
  assign dout       = mem[rd_ptr];

  assign wr_en = din_valid && din_ready;
  assign rd_en = dout_valid && dout_ready;

  always_ff @(posedge pcie_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
    if (pcie_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: pcie_read_pkg.sv
package pcie_read_pkg;

  // Slot geometry
  localparam int slot_count  = 8;
  localparam int slot_w      = 3;
  localparam int slot_bytes  = 256;

  // Stream and scratchpad words
  localparam int data_w      = 128;
  localparam int keep_w      = 16;
  localparam int ram_addr_w  = 7;

  localparam int pcie_addr_w = 64;
  localparam int host_tag_w  = 32;
  localparam int len_w       = 16;
  localparam int core_w      = 4;
  localparam int core_addr_w = 16;
  localparam int dest_w      = 9;

  // ram_addr carries the core address in 15:0 and the core id in 19:16
  typedef struct packed {
    logic [pcie_addr_w-1:0] pcie_addr;
    logic [31:0]            ram_addr;
    logic [len_w-1:0]       len;
    logic [host_tag_w-1:0]  tag;
  } host_req_t;

  // 128-bit control word from a core
  typedef struct packed {
    logic [pcie_addr_w-1:0]     pcie_addr;
    logic [15:0]                unused_hi;
    logic [core_addr_w-1:0]     core_addr;
    logic [10:0]                unused_mid;
    logic [dest_w-core_w-1:0]   dest_lo;
    logic [len_w-1:0]           len;
  } core_ctrl_t;

  typedef struct packed {
    logic [pcie_addr_w-1:0] pcie_addr;
    logic [15:0]            ram_addr;
    logic [len_w-1:0]       len;
    logic [slot_w-1:0]      tag;
  } dma_desc_t;

  // Zero host_tag means no host status
  typedef struct packed {
    logic [len_w-1:0]       len;
    logic [core_addr_w-1:0] core_addr;
    logic [dest_w-1:0]      dest;
    logic [host_tag_w-1:0]  host_tag;
  } slot_rec_t;

  typedef struct packed {
    logic [slot_w-1:0] slot;
    slot_rec_t         rec;
  } stream_desc_t;

  typedef struct packed {
    logic [ram_addr_w-1:0] addr;
    logic [data_w-1:0]     data;
    logic [keep_w-1:0]     be;
  } ram_wr_t;

  typedef enum logic [1:0] {
    s_idle,
    s_header,
    s_data
  } stream_state_e;

endpackage
